/* project.f */
logic/ssc_pkg.sv
logic/card_checker.sv
logic/cost_sorter.sv
logic/change_calculator.sv
logic/ssc_top.sv
sim/tb_clock_gen.sv
sim/ssc_properties.sv
sim/tb_ssc.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the snack shopping calculator testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module tb_ssc \
        -Mdir obj_dir -o tb_ssc -f project.f; then
    echo "build failed"
    exit 1
fi

if ! ./obj_dir/tb_ssc; then
    echo "simulation reported a failure"
    exit 1
fi

exit 0

/* sim/tb_ssc.sv */
// =========================================================
// testbench of the snack shopping calculator
// directed and random requests every cycle, each result
// checked against a reference model two cycles later
// =========================================================

`timescale 1ns/1ns
`default_nettype none

module tb_ssc import ssc_pkg::*; ();

    localparam int CLK_PERIOD = 10;
    localparam int N_DIR      = 7;
    localparam int N_RAND     = 200;
    localparam int N_REQ      = N_DIR + N_RAND;

    // expected outputs and the cycle they are due in
    typedef struct packed {
        int unsigned        due;
        logic               ok;
        logic [MONEY_W-1:0] change;
    } expect_t;

    logic               clk;
    logic               arst_n;
    card_t              card;
    logic [MONEY_W-1:0] money;
    snack_req_t         snacks;
    logic               card_ok;
    logic [MONEY_W-1:0] change;
    expect_t            exp_q[$];
    int unsigned        cyc;
    int                 n_checked;

    tb_clock_gen i_clock_gen (.clk(clk), .arst_n(arst_n));

    ssc_top i_dut (
        .clk     (clk),
        .arst_n  (arst_n),
        .card    (card),
        .money   (money),
        .snacks  (snacks),
        .card_ok (card_ok),
        .change  (change)
    );

    // Luhn digit sum, doubling starts at the leading digit
    function automatic int luhn_total(input card_t c);
        int d;
        int total;
        total = 0;
        for (int p = 0; p < NUM_DIGITS; p++) begin
            d = int'(c[NUM_DIGITS-1-p]);
            if (p % 2 == 0) begin
                d = 2 * d;
                if (d > 9) begin
                    d = d - 9;
                end
            end
            total += d;
        end
        return total;
    endfunction

    // =========================================================
    // reference model
    // =========================================================
    function automatic expect_t ref_result(input card_t c, input logic [MONEY_W-1:0] m,
                                           input snack_req_t s);
        int      cost [NUM_SNACKS];
        int      tmp;
        int      remain;
        bit      stop;
        expect_t e;
        for (int i = 0; i < NUM_SNACKS; i++) begin
            cost[i] = int'(s.count[i]) * int'(s.price[i]);
        end
        // bubble sort, largest first
        for (int i = 0; i < NUM_SNACKS - 1; i++) begin
            for (int j = 0; j < NUM_SNACKS - 1 - i; j++) begin
                if (cost[j] < cost[j+1]) begin
                    tmp       = cost[j];
                    cost[j]   = cost[j+1];
                    cost[j+1] = tmp;
                end
            end
        end
        // greedy buy, first unaffordable cost ends it
        remain = int'(m);
        stop   = 1'b0;
        for (int i = 0; i < NUM_SNACKS; i++) begin
            if (!stop && cost[i] > remain) begin
                stop = 1'b1;
            end else if (!stop) begin
                remain -= cost[i];
            end
        end
        e.due    = 0;
        e.ok     = (luhn_total(c) % 10 == 0);
        e.change = e.ok ? MONEY_W'(remain) : m;
        return e;
    endfunction

    // random digits, optionally with a fitting check digit
    function automatic card_t random_card(input bit make_valid);
        card_t c;
        int    s;
        for (int i = 0; i < NUM_DIGITS; i++) begin
            c[i] = DIGIT_W'($urandom_range(9, 0));
        end
        if (make_valid) begin
            c[0] = '0;
            s    = luhn_total(c);
            c[0] = DIGIT_W'((10 - s % 10) % 10);
        end
        return c;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
            $display("Verification failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // one request per falling edge, result due two edges on
    task automatic drive_request(input card_t c, input logic [MONEY_W-1:0] m,
                                 input snack_req_t s);
        expect_t e;
        @(negedge clk);
        card   = c;
        money  = m;
        snacks = s;
        e      = ref_result(c, m, s);
        e.due  = cyc + 2;
        exp_q.push_back(e);
    endtask

    // =========================================================
    // stimulus
    // =========================================================
    initial begin
        // idle card fails the Luhn check, outputs stay clear
        card   = 64'h0000_0000_0000_0001;
        money  = '0;
        snacks = '0;
        void'($urandom(97));
        wait (arst_n == 1'b1);
        // all affordable, costs 1..8
        drive_request(64'h4539_1488_0343_6467, 9'd100, 64'h12345678_11111111);
        // bad check digit, money back
        drive_request(64'h4539_1488_0343_6468, 9'd200, 64'h12345678_11111111);
        // nothing affordable
        drive_request(64'h4539_1488_0343_6467, 9'd5, 64'h33333333_33333333);
        // all costs zero
        drive_request(64'h0000_0000_0000_0000, 9'd300, 64'h00000000_ffffffff);
        // 100 bought, 50 fails, 40 and 1 left alone
        drive_request(64'h0000_0799_2739_8713, 9'd140, 64'h1a0a8000_150a5000);
        // maximum costs and money
        drive_request(64'h0000_0799_2739_8713, 9'd511, 64'hffffffff_ffffffff);
        drive_request(64'h0000_0799_2739_8710, 9'd511, 64'hffffffff_ffffffff);
        // back-to-back random traffic
        repeat (N_RAND) begin
            drive_request(random_card($urandom_range(1, 0) == 1),
                          MONEY_W'($urandom_range(511, 0)),
                          snack_req_t'({$urandom, $urandom}));
        end
        repeat (3) @(negedge clk);
        if (n_checked == N_REQ && exp_q.size() == 0) begin
            $display("Verification passed");
            $finish;
        end else begin
            $display("not every request produced a result");
            $display("Verification failed");
            $fatal(1, "missing results");
        end
    end

    // compare just after each rising edge
    initial begin : compare_results
        expect_t e;
        cyc       = 0;
        n_checked = 0;
        forever begin
            @(posedge clk);
            cyc++;
            #1;
            if (arst_n && exp_q.size() > 0 && exp_q[0].due == cyc) begin
                e = exp_q.pop_front();
                check_value("card_ok", 32'(card_ok), 32'(e.ok));
                check_value("change", 32'(change), 32'(e.change));
                n_checked++;
            end else if (n_checked == 0) begin
                // reset values hold until the first result
                check_value("card_ok", 32'(card_ok), 32'd0);
                check_value("change", 32'(change), 32'd0);
            end
        end
    end

    // watchdog
    initial begin
        #((N_REQ + 20) * CLK_PERIOD);
        $display("watchdog timeout, the run did not finish in time");
        $display("Verification failed");
        $fatal(1, "timeout");
    end

endmodule

`default_nettype wire

/* sim/ssc_properties.sv */
// =========================================================
// concurrent checks on the output stage, bound into every
// change_calculator; reset state and money vs change rules
// =========================================================

`timescale 1ns/1ns
`default_nettype none

module ssc_properties import ssc_pkg::*; (
    input wire                clk,
    input wire                arst_n,
    input sorted_cost_t       sorted,
    input wire                card_ok,
    input wire [MONEY_W-1:0]  change
);

    // outputs held clear while reset is low
    reset_clear: assert property (@(posedge clk)
        !arst_n |-> (card_ok == 1'b0 && change == '0))
        else $error("outputs not clear during reset");

    // a purchase only ever takes money away
    change_bound: assert property (@(posedge clk) disable iff (!arst_n)
        change <= $past(sorted.money))
        else $error("change exceeds the money of its request");

    // invalid card returns the money as it came in
    refund_on_invalid: assert property (@(posedge clk) disable iff (!arst_n)
        !card_ok |-> change == $past(sorted.money))
        else $error("money not returned for an invalid card");

endmodule

bind change_calculator ssc_properties i_ssc_properties (
    .clk     (clk),
    .arst_n  (arst_n),
    .sorted  (sorted),
    .card_ok (card_ok),
    .change  (change)
);

`default_nettype wire

/* sim/tb_clock_gen.sv */
// =========================================================
// testbench clock and reset, 10 ns period, reset held low
// for eight cycles and released on a falling edge
// =========================================================

`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic arst_n
);

    localparam int HALF_PERIOD  = 5;
    localparam int RESET_CYCLES = 8;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // release away from the sampling edge
    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
    end

endmodule

`default_nettype wire

/* logic/ssc_top.sv */
// =========================================================
// snack shopping calculator, top level
// card check and cost sort run side by side, the change
// stage joins them; result two cycles after the request
// =========================================================

`timescale 1ns/1ns
`default_nettype none

module ssc_top import ssc_pkg::*; (
    input  wire                 clk,
    input  wire                 arst_n,
    input  card_t               card,
    input  wire  [MONEY_W-1:0]  money,
    input  snack_req_t          snacks,
    output logic                card_ok,
    output logic [MONEY_W-1:0]  change
);

    // stage 1 to stage 2
    logic         card_ok_q;
    sorted_cost_t sorted;

    // Luhn check
    card_checker i_card_checker (
        .clk       (clk),
        .arst_n    (arst_n),
        .card      (card),
        .card_ok_q (card_ok_q)
    );

    // cost multiply and sort
    cost_sorter i_cost_sorter (
        .clk    (clk),
        .arst_n (arst_n),
        .snacks (snacks),
        .money  (money),
        .sorted (sorted)
    );

    // purchase and output select
    change_calculator i_change_calculator (
        .clk       (clk),
        .arst_n    (arst_n),
        .card_ok_q (card_ok_q),
        .sorted    (sorted),
        .card_ok   (card_ok),
        .change    (change)
    );

endmodule

`default_nettype wire

/* logic/change_calculator.sv */
// =========================================================
// greedy purchase over the sorted costs and change select
// second pipeline stage, drives the registered card_ok and
// change outputs of the calculator
// =========================================================

`timescale 1ns/1ns
`default_nettype none

module change_calculator import ssc_pkg::*; (
    input  wire                 clk,
    input  wire                 arst_n,
    input  wire                 card_ok_q,
    input  sorted_cost_t        sorted,
    output logic                card_ok,
    output logic [MONEY_W-1:0]  change
);

    // money left after the greedy purchase
    logic [MONEY_W-1:0] buy_change;

    // =========================================================
    // subtract chain
    // =========================================================
    // extra top bit is the borrow of each subtraction
    always_comb begin : greedy_buy
        logic [MONEY_W:0] remain;
        logic [MONEY_W:0] diff;
        logic             affordable;
        remain     = {1'b0, sorted.money};
        affordable = 1'b1;
        for (int i = 0; i < NUM_SNACKS; i++) begin
            diff = remain - (MONEY_W+1)'(sorted.cost[i]);
            // first borrow ends the purchase for good
            affordable = affordable & ~diff[MONEY_W];
            if (affordable) begin
                remain = diff;
            end
        end
        // borrow bit is clear here, remain never goes negative
        buy_change = remain[MONEY_W-1:0];
    end

    // =========================================================
    // output register
    // =========================================================
    // invalid card hands the money back untouched
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            card_ok <= 1'b0;
            change  <= '0;
        end else begin
            card_ok <= card_ok_q;
            change  <= card_ok_q ? buy_change : sorted.money;
        end
    end

endmodule

`default_nettype wire

/* logic/cost_sorter.sv */
// =========================================================
// per-snack cost and descending sort of the eight costs
// first pipeline stage, sorted costs registered together
// with the money so both line up with card_ok_q
// =========================================================

`timescale 1ns/1ns
`default_nettype none

module cost_sorter import ssc_pkg::*; (
    input  wire                clk,
    input  wire                arst_n,
    input  snack_req_t         snacks,
    input  wire  [MONEY_W-1:0] money,
    output sorted_cost_t       sorted
);

    // one compare-exchange result, larger value first
    typedef struct packed {
        logic [COST_W-1:0] hi;
        logic [COST_W-1:0] lo;
    } pair_t;

    typedef logic [0:3][COST_W-1:0] quad_t;

    logic [0:NUM_SNACKS-1][COST_W-1:0] cost;
    logic [0:NUM_SNACKS-1][COST_W-1:0] cost_desc;
    quad_t                             half_a;
    quad_t                             half_b;

    // compare-exchange
    function automatic pair_t cas(input logic [COST_W-1:0] x, input logic [COST_W-1:0] y);
        pair_t p;
        p.hi = (x > y) ? x : y;
        p.lo = (x > y) ? y : x;
        return p;
    endfunction

    // four-input descending sort
    function automatic quad_t sort4(input quad_t q);
        pair_t p0, p1, p2, p3, p4;
        quad_t r;
        p0 = cas(q[0], q[1]);
        p1 = cas(q[2], q[3]);
        // max and min fall out of the second layer
        p2 = cas(p0.hi, p1.hi);
        p3 = cas(p0.lo, p1.lo);
        // middle pair still unordered
        p4 = cas(p2.lo, p3.hi);
        r[0] = p2.hi;
        r[1] = p4.hi;
        r[2] = p4.lo;
        r[3] = p3.lo;
        return r;
    endfunction

    // =========================================================
    // cost per snack
    // =========================================================
    always_comb begin
        for (int i = 0; i < NUM_SNACKS; i++) begin
            cost[i] = COST_W'(snacks.count[i]) * COST_W'(snacks.price[i]);
        end
    end

    // two sorted halves
    assign half_a = sort4(cost[0:3]);
    assign half_b = sort4(cost[4:7]);

    // =========================================================
    // odd-even merge, nine comparators
    // =========================================================
    always_comb begin : merge_net
        pair_t s2a, s2b, s2c, s2d, s3a, s3b, s4a, s4b, s4c;
        // rank-wise compare of both halves
        s2a = cas(half_a[0], half_b[0]);
        s2b = cas(half_a[1], half_b[1]);
        s2c = cas(half_a[2], half_b[2]);
        s2d = cas(half_a[3], half_b[3]);
        // cross fix-up
        s3a = cas(s2a.lo, s2c.hi);
        s3b = cas(s2b.lo, s2d.hi);
        // final neighbours
        s4a = cas(s2b.hi, s3a.hi);
        s4b = cas(s3a.lo, s3b.hi);
        s4c = cas(s2c.lo, s3b.lo);
        cost_desc[0] = s2a.hi;
        cost_desc[1] = s4a.hi;
        cost_desc[2] = s4a.lo;
        cost_desc[3] = s4b.hi;
        cost_desc[4] = s4b.lo;
        cost_desc[5] = s4c.hi;
        cost_desc[6] = s4c.lo;
        cost_desc[7] = s2d.lo;
    end

    // stage register, money kept next to its costs
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sorted <= '0;
        end else begin
            sorted.cost  <= cost_desc;
            sorted.money <= money;
        end
    end

endmodule

`default_nettype wire

/* logic/card_checker.sv */
// =========================================================
// Luhn check of the 16-digit card number
// first pipeline stage, result registered as card_ok_q one
// cycle after the card is sampled
// =========================================================

`timescale 1ns/1ns
`default_nettype none

module card_checker import ssc_pkg::*; (
    input  wire   clk,
    input  wire   arst_n,
    input  card_t card,
    output logic  card_ok_q
);

    // eight bits cover the worst case, 16 * 9 = 144
    localparam int SUM_W    = 8;
    // highest multiple of ten below 144 is 14 * 10
    localparam int MAX_MULT = 14;

    logic [SUM_W-1:0] digit_sum;
    logic             card_valid;

    // =========================================================
    // digit transform and sum
    // =========================================================
    always_comb begin : luhn_sum
        logic [DIGIT_W:0]   dbl;
        logic [DIGIT_W-1:0] val;
        digit_sum = '0;
        for (int i = 0; i < NUM_DIGITS; i++) begin
            // odd index means every second digit from the top
            dbl = {card[i], 1'b0};
            if (i % 2 == 1) begin
                // 2d - 9 once the doubled digit leaves 0..9
                val = (card[i] > DIGIT_W'(4)) ? DIGIT_W'(dbl - (DIGIT_W+1)'(9))
                                              : dbl[DIGIT_W-1:0];
            end else begin
                val = card[i];
            end
            digit_sum = digit_sum + SUM_W'(val);
        end
    end

    // =========================================================
    // multiple-of-ten test
    // =========================================================
    // plain equality compares, no divider
    always_comb begin : mod10_check
        card_valid = 1'b0;
        for (int k = 0; k <= MAX_MULT; k++) begin
            card_valid = card_valid | (digit_sum == SUM_W'(k * 10));
        end
    end

    // stage register
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            card_ok_q <= 1'b0;
        end else begin
            card_ok_q <= card_valid;
        end
    end

endmodule

`default_nettype wire

/* logic/ssc_pkg.sv */
// =========================================================
// shared widths, counts and bus types of the snack shopping
// calculator; every RTL block imports this package whole
// =========================================================

`default_nettype none

package ssc_pkg;

    // =========================================================
    // field sizes
    // =========================================================
    // card digits, one decimal digit per nibble
    localparam int NUM_DIGITS = 16;
    localparam int DIGIT_W    = 4;

    // snack kinds, count and unit price share one nibble width
    localparam int NUM_SNACKS = 8;
    localparam int QTY_W      = 4;

    // count times price, 15 * 15 fits in eight bits
    localparam int COST_W     = 8;

    // money in and change out
    localparam int MONEY_W    = 9;

    // =========================================================
    // bus types
    // =========================================================
    // digit 15 is the most significant and the first one doubled
    typedef logic [NUM_DIGITS-1:0][DIGIT_W-1:0] card_t;

    // snack 0 sits in the top nibble of each group
    typedef struct packed {
        logic [0:NUM_SNACKS-1][QTY_W-1:0] count;
        logic [0:NUM_SNACKS-1][QTY_W-1:0] price;
    } snack_req_t;

    // cost[0] is the largest, money rides along unchanged
    typedef struct packed {
        logic [0:NUM_SNACKS-1][COST_W-1:0] cost;
        logic [MONEY_W-1:0]                money;
    } sorted_cost_t;

endpackage

`default_nettype wire
